// File: include/pkt_csum_cfg.svh
`ifndef PKT_CSUM_CFG_SVH
`define PKT_CSUM_CFG_SVH

// Width of one word on every stream link of the checksum inserter
`define PKT_CSUM_WORD_W 16

// Width of the running one's-complement sum and of the trailer checksum
// It has to match the word width because the trailer travels as a data word
`define PKT_CSUM_CSUM_W 16

`endif

// File: hdl/pkt_csum_pkg.sv
`include "pkt_csum_cfg.svh"

package pkt_csum_pkg;

  // ----------------------------------------------------------------------
  // Datapath types
  // ----------------------------------------------------------------------

  // One payload word as it moves along the stream
  typedef logic [`PKT_CSUM_WORD_W-1:0] word_t;

  // Running one's-complement sum, and also the final inverted checksum
  typedef logic [`PKT_CSUM_CSUM_W-1:0] csum_t;

  // ----------------------------------------------------------------------
  // Control types
  // ----------------------------------------------------------------------

  // PASS forwards packet words and TRAILER presents the checksum word
  typedef enum logic {
    PASS    = 1'b0,
    TRAILER = 1'b1
  } ctrl_state_e;

endpackage

// File: hdl/word_stream_if.sv
// Ready/valid word stream with an end-of-packet flag
// A word moves in any cycle where valid and ready are both high
// The source holds valid, data and last steady while ready is low
interface word_stream_if;

  import pkt_csum_pkg::*;

  // Source side qualifiers and payload
  logic  valid;
  word_t data;
  logic  last;

  // Sink side back-pressure
  logic  ready;

  // Producer end of a link
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  // Consumer end of a link
  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

// File: hdl/flow_reg_fwd.sv
// One-entry pipeline register on a ready/valid stream
// Behaves like a FIFO of depth one with a cut-through back-pressure path
module flow_reg_fwd (
  input logic           clk,
  input logic           rst_n,
  word_stream_if.sink   push,
  word_stream_if.source pop
);

  import pkt_csum_pkg::*;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  // Occupancy flag, this is the only state that needs a reset
  logic  valid_q;

  // Held word and its end-of-packet flag, qualified by valid_q
  word_t data_q;
  logic  last_q;

  // High when a word moves from upstream into this stage
  logic  load_en;

  // The stage can take a word if it is empty or if it drains this cycle
  assign push.ready = pop.ready || !valid_q;
  assign load_en    = push.valid && push.ready;

  // The stage stays full on a stall and otherwise follows push valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (push.ready) begin
      valid_q <= push.valid;
    end
  end

  // Payload only moves on a push transfer
  always_ff @(posedge clk) begin
    if (load_en) begin
      data_q <= push.data;
      last_q <= push.last;
    end
  end

  assign pop.valid = valid_q;
  assign pop.data  = data_q;
  assign pop.last  = last_q;

  // ----------------------------------------------------------------------
  // Protocol checks
  // ----------------------------------------------------------------------

  // A stalled word must still be there with the same payload next cycle
  pop_stall_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
    pop.valid && !pop.ready |=> pop.valid && $stable(pop.data) && $stable(pop.last))
    else $error("flow_reg_fwd pop side changed while stalled");

  // The stage is empty and accepting in the first cycle out of reset
  reset_ready_a : assert property (@(posedge clk) $rose(rst_n) |-> push.ready)
    else $error("flow_reg_fwd not ready after reset");

  // A word taken on the push side is presented on the pop side next cycle
  push_to_pop_a : assert property (@(posedge clk) disable iff (!rst_n)
    load_en |=> pop.valid && pop.data == $past(push.data) && pop.last == $past(push.last))
    else $error("flow_reg_fwd pushed word missing from the pop side");

endmodule

// File: hdl/csum_accum.sv
`include "pkt_csum_cfg.svh"

// One's-complement accumulator for the packet checksum
// The carry out of the top bit wraps back into bit 0 on every add
module csum_accum (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                add_en,
  input  pkt_csum_pkg::word_t add_word,
  input  logic                clear,
  output pkt_csum_pkg::csum_t csum
);

  import pkt_csum_pkg::*;

  // Running sum of every word accepted so far in the current packet
  csum_t sum_q;

  // Plain binary sum with one extra bit to catch the carry
  logic [`PKT_CSUM_CSUM_W:0] raw_sum;

  // Sum after the end-around carry is folded back in
  csum_t folded_sum;

  assign raw_sum = {1'b0, sum_q} + {1'b0, csum_t'(add_word)};

  // A second carry cannot occur here
  // The largest raw sum is 0x1FFFE, which folds to 0xFFFF
  assign folded_sum = raw_sum[`PKT_CSUM_CSUM_W-1:0]
                    + {{(`PKT_CSUM_CSUM_W-1){1'b0}}, raw_sum[`PKT_CSUM_CSUM_W]};

  // ----------------------------------------------------------------------
  // Sum register
  // ----------------------------------------------------------------------

  // Clear wins the priority, though the controller never sends both
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (clear) begin
      sum_q <= '0;
    end else if (add_en) begin
      sum_q <= folded_sum;
    end
  end

  // Checksum is the one's complement of the running sum
  assign csum = ~sum_q;

  // The trailer cycle and the data cycles of a packet never overlap
  add_clear_excl_a : assert property (@(posedge clk) disable iff (!rst_n)
    !(add_en && clear))
    else $error("csum_accum add_en and clear high together");

endmodule

// File: hdl/trailer_ctrl.sv
// Controller between the input and output pipeline registers
// Forwards packet words and then inserts the checksum as a trailer word
module trailer_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  word_stream_if.sink         up,
  word_stream_if.source       down,
  output logic                add_en,
  output pkt_csum_pkg::word_t add_word,
  output logic                clear,
  input  pkt_csum_pkg::csum_t csum
);

  import pkt_csum_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Transfers on both links as seen by this block
  logic up_xfer;
  logic down_xfer;

  assign up_xfer   = up.valid && up.ready;
  assign down_xfer = down.valid && down.ready;

  // The accumulator always sees the upstream word
  // Only add_en decides whether it counts
  assign add_word = up.data;

  // ----------------------------------------------------------------------
  // Next state and link muxing
  // ----------------------------------------------------------------------

  always_comb begin
    state_d    = state_q;
    up.ready   = 1'b0;
    down.valid = 1'b0;
    down.data  = up.data;
    down.last  = 1'b0;
    add_en     = 1'b0;
    clear      = 1'b0;

    case (state_q)
      PASS: begin
        // Straight pass-through with the end-of-packet flag stripped
        up.ready   = down.ready;
        down.valid = up.valid;
        down.data  = up.data;
        down.last  = 1'b0;
        add_en     = up_xfer;
        if (up_xfer && up.last) begin
          state_d = TRAILER;
        end
      end

      TRAILER: begin
        // Upstream waits while the checksum word goes out
        up.ready   = 1'b0;
        down.valid = 1'b1;
        down.data  = word_t'(csum);
        down.last  = 1'b1;
        if (down_xfer) begin
          clear   = 1'b1;
          state_d = PASS;
        end
      end

      default: begin
        state_d = PASS;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= PASS;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // The word after a packet's last word is held off until the trailer is out
  trailer_blocks_up_a : assert property (@(posedge clk) disable iff (!rst_n)
    up_xfer && up.last |=> state_q == TRAILER && !up.ready)
    else $error("trailer_ctrl accepted a word before the trailer");

  // Clear only comes with an outgoing trailer and ends the trailer state
  clear_on_trailer_a : assert property (@(posedge clk) disable iff (!rst_n)
    clear |-> down_xfer && down.last ##1 state_q == PASS)
    else $error("trailer_ctrl clear without a trailer transfer");

endmodule

// File: hdl/pkt_csum_top.sv
// Packet checksum inserter
// Input register, trailer controller and output register in a chain
// The accumulator sits beside the controller
module pkt_csum_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  pkt_csum_pkg::word_t in_data,
  input  logic                in_last,
  output logic                out_valid,
  input  logic                out_ready,
  output pkt_csum_pkg::word_t out_data,
  output logic                out_last
);

  import pkt_csum_pkg::*;

  // ----------------------------------------------------------------------
  // Stream links
  // ----------------------------------------------------------------------

  word_stream_if s_in ();
  word_stream_if s_mid ();
  word_stream_if s_out ();
  word_stream_if s_pop ();

  // Accumulator control and result
  logic  add_en;
  word_t add_word;
  logic  clear;
  csum_t csum;

  // Input ports onto the first link
  assign s_in.valid = in_valid;
  assign s_in.data  = in_data;
  assign s_in.last  = in_last;
  assign in_ready   = s_in.ready;

  // Pop side of the output register onto the output ports
  assign out_valid   = s_pop.valid;
  assign out_data    = s_pop.data;
  assign out_last    = s_pop.last;
  assign s_pop.ready = out_ready;

  // ----------------------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------------------

  flow_reg_fwd u_in_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (s_in.sink),
    .pop   (s_mid.source)
  );

  trailer_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .up       (s_mid.sink),
    .down     (s_out.source),
    .add_en   (add_en),
    .add_word (add_word),
    .clear    (clear),
    .csum     (csum)
  );

  csum_accum u_csum (
    .clk      (clk),
    .rst_n    (rst_n),
    .add_en   (add_en),
    .add_word (add_word),
    .clear    (clear),
    .csum     (csum)
  );

  flow_reg_fwd u_out_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (s_out.sink),
    .pop   (s_pop.source)
  );

endmodule

// File: bench/pkt_csum_tb.sv
module pkt_csum_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import pkt_csum_pkg::*;

  // Cycle limits for the handshake waits
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  logic  in_ready;
  word_t in_data;
  logic  in_last;
  logic  out_valid;
  logic  out_ready;
  word_t out_data;
  logic  out_last;

  // Expected output entries, one per data word and one per trailer
  word_t exp_data[$];
  logic  exp_last[$];

  // Input transfer cycles, used for the latency check
  int    in_times[$];

  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    tests_bad = 0;
  int    cycle = 0;
  bit    timing_on = 1'b0;
  bit    random_ready = 1'b0;

  // Word held on the output port while out_ready is low
  bit    stall_seen = 1'b0;
  word_t held_data;
  logic  held_last;

  pkt_csum_top i_pkt_csum_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Sink side back-pressure, either steady or a coin flip per cycle
  initial begin
    int unsigned r;
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      r = $urandom;
      out_ready = random_ready ? r[0] : 1'b1;
    end
  end

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("FAILED %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while %s", what);
    $display("Some tests failed");
    $finish;
  endtask

  // A stalled output word must not be withdrawn
  out_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else begin
      errors++;
      $display("out_valid dropped while out_ready was low");
    end

  // ----------------------------------------------------------------------
  // Output monitor
  // ----------------------------------------------------------------------

  always @(posedge clk) begin : monitor
    word_t exp_word;
    logic  exp_flag;
    int    t_in;
    if (rst_n) begin
      // Payload has to stay put across a stall
      if (stall_seen) begin
        check_word("out_data", held_data, out_data);
        check_word("out_last", {15'd0, held_last}, {15'd0, out_last});
      end
      stall_seen = out_valid && !out_ready;
      held_data  = out_data;
      held_last  = out_last;
      if (timing_on && in_valid && in_ready) begin
        in_times.push_back(cycle);
      end
      if (out_valid && out_ready) begin
        if (exp_data.size() == 0) begin
          errors++;
          $display("Output word %h arrived while nothing was expected", out_data);
        end else begin
          exp_word = exp_data.pop_front();
          exp_flag = exp_last.pop_front();
          check_word("out_data", exp_word, out_data);
          check_word("out_last", {15'd0, exp_flag}, {15'd0, out_last});
          // Data words take two cycles through the two registers
          if (timing_on && !exp_flag) begin
            if (in_times.size() == 0) begin
              errors++;
              $display("Output data word without a recorded input transfer");
            end else begin
              t_in = in_times.pop_front();
              check_word("out_valid latency", 16'd2, 16'(cycle - t_in));
            end
          end
        end
      end
    end
    cycle++;
  end

  // ----------------------------------------------------------------------
  // Reference model and stimulus
  // ----------------------------------------------------------------------

  // Sum with the carries gathered at the top, folded until none is left
  function automatic word_t expected_checksum(input word_t words[$]);
    int unsigned total;
    total = 0;
    foreach (words[i]) begin
      total = total + {16'd0, words[i]};
    end
    while (total > 32'h0000_FFFF) begin
      total = (total & 32'h0000_FFFF) + (total >> 16);
    end
    return ~total[15:0];
  endfunction

  task automatic drive_word(input word_t data, input logic last);
    int waited;
    bit taken;
    waited   = 0;
    taken    = 1'b0;
    in_valid = 1'b1;
    in_data  = data;
    in_last  = last;
    while (!taken) begin
      // in_ready has settled 1 ns after the inputs and out_ready changed
      #1;
      taken = in_ready;
      @(posedge clk);
      #2;
      waited++;
      if (!taken && waited > WAIT_LIMIT) begin
        stop_on_timeout("waiting for in_ready");
      end
    end
  endtask

  task automatic send_packet(input word_t words[$]);
    foreach (words[i]) begin
      exp_data.push_back(words[i]);
      exp_last.push_back(1'b0);
    end
    exp_data.push_back(expected_checksum(words));
    exp_last.push_back(1'b1);
    foreach (words[i]) begin
      drive_word(words[i], i == words.size() - 1);
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
  endtask

  task automatic send_repeated(input word_t w, input int n);
    word_t words[$];
    repeat (n) begin
      words.push_back(w);
    end
    send_packet(words);
  endtask

  task automatic send_random(input int len);
    word_t       words[$];
    int unsigned r;
    repeat (len) begin
      r = $urandom;
      words.push_back(r[15:0]);
    end
    send_packet(words);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > DRAIN_LIMIT) begin
        stop_on_timeout("waiting for the output stream to drain");
      end
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    tests_run++;
    if (errors != start_errors) begin
      tests_bad++;
    end
    $display("Test %0d %s: %0d errors", tests_run, name, errors - start_errors);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int          start;
    int unsigned r;
    word_t       pair[$];
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    in_last  = 1'b0;
    void'($urandom(9867));

    // Both registers empty in reset and one cycle after it
    start = errors;
    repeat (8) begin
      @(posedge clk);
      #2;
      check_word("out_valid", 16'd0, {15'd0, out_valid});
      check_word("in_ready", 16'd1, {15'd0, in_ready});
    end
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_word("out_valid", 16'd0, {15'd0, out_valid});
    check_word("in_ready", 16'd1, {15'd0, in_ready});
    end_test("reset state", start);

    start     = errors;
    timing_on = 1'b1;
    send_random(6);
    wait_drain();
    timing_on = 1'b0;
    end_test("pass-through order and latency", start);

    // Single word, then packets whose sums wrap through the end-around carry
    start = errors;
    send_repeated(16'h1234, 1);
    send_repeated(16'hFFFF, 4);
    send_repeated(16'h8000, 4);
    pair.push_back(16'hFFFF);
    pair.push_back(16'h0001);
    send_packet(pair);
    wait_drain();
    end_test("trailer checksum", start);

    start        = errors;
    random_ready = 1'b1;
    repeat (6) begin
      r = $urandom;
      send_random(1 + int'(r % 12));
    end
    wait_drain();
    random_ready = 1'b0;
    end_test("random back-pressure", start);

    start = errors;
    repeat (10) begin
      r = $urandom;
      send_random(1 + int'(r % 12));
    end
    wait_drain();
    end_test("back-to-back packets", start);

    $display("Tests run: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: pkt_csum.f
+incdir+include
hdl/pkt_csum_pkg.sv
hdl/word_stream_if.sv
hdl/flow_reg_fwd.sv
hdl/csum_accum.sv
hdl/trailer_ctrl.sv
hdl/pkt_csum_top.sv
bench/pkt_csum_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the checksum inserter testbench with Verilator and run it
# The run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/100ps \
  --top-module pkt_csum_tb -f pkt_csum.f -Mdir obj_dir -o pkt_csum_sim \
  && ./obj_dir/pkt_csum_sim | tee /dev/stderr | grep -qx "All tests passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
